// File: DecodeStage.f
+incdir+verilog
verilog/DecodePkg.sv
verilog/ControlUnit.sv
verilog/ImmGen.sv
verilog/IdExReg.sv
verilog/DecodeStage.sv
tests/DecodeStage_sva.sv
tests/DecodeStageTb.sv

// File: run.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --assert --timing --top-module DecodeStageTb \
    -f DecodeStage.f -o DecodeStageSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/DecodeStageSim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST RESULT: PASS" "$log"; then
    exit 0
fi
echo "Pass message not found in $log"
exit 1

// File: tests/DecodeStageTb.sv
`include "decode_params.svh"

module DecodeStageTb;

    timeunit 1ns;
    timeprecision 1ps;

    import DecodePkg::*;

    localparam int numRandom = 2000;
    localparam int numCycles = numRandom + 60;  // Reset and directed part included
    localparam logic [6:0] opList [13] = '{7'b0110011, 7'b0000011, 7'b0010011, 7'b1100111,
        7'b0100011, 7'b1100011, 7'b0010111, 7'b0110111, 7'b1101111, 7'b1110011,
        7'b0000111, 7'b0100111, 7'b1010011};

    logic        clk;
    logic        rstN;
    instrT       instr;
    logic        instrValid;
    logic        stall;
    logic        flush;
    idExT        idEx;
    idExT        model;
    logic [31:0] rng;

    DecodeStage DUT (.*);

    bind DecodeStage DecodeStageSva uSva (
        .clk(clk), .rstN(rstN), .stall(stall), .flush(flush), .idEx(idEx)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    // Flag order is aluSrc pcToRegSrc rdSrc, then memToReg memWrite memRead regWrite,
    // then regWriteF aluSelF memInF
    function automatic ctrlT makeCtrl(input aluOpT op, input immTypeT it, input branchT br,
                                      input logic [9:0] f);
        ctrlT c;
        c.aluOp   = op;
        c.immType = it;
        c.branch  = br;
        {c.aluSrc, c.pcToRegSrc, c.rdSrc, c.memToReg, c.memWrite, c.memRead,
         c.regWrite, c.regWriteF, c.aluSelF, c.memInF} = f;
        return c;
    endfunction

    function automatic ctrlT controlRow(input logic [6:0] op);
        case (op)
            7'b0110011: return makeCtrl(aluR,   immNone, brNone, 10'b100_1001_011);
            7'b0000011: return makeCtrl(aluAdd, immI,    brNone, 10'b000_0011_011);
            7'b0010011: return makeCtrl(aluI,   immI,    brNone, 10'b000_1001_011);
            7'b1100111: return makeCtrl(aluAdd, immI,    brJalr, 10'b001_1001_011);
            7'b0100011: return makeCtrl(aluAdd, immS,    brNone, 10'b000_0100_011);
            7'b1100011: return makeCtrl(aluBr,  immB,    brCond, 10'b111_0000_011);
            7'b0010111: return makeCtrl(aluAdd, immU,    brNone, 10'b011_1001_011);
            7'b0110111: return makeCtrl(aluLui, immU,    brNone, 10'b000_1001_011);
            7'b1101111: return makeCtrl(aluAdd, immJ,    brJal,  10'b001_1001_011);
            7'b1110011: return makeCtrl(aluCsr, immI,    brNone, 10'b000_0001_011);
            7'b0000111: return makeCtrl(aluAdd, immI,    brNone, 10'b000_0010_111);
            7'b0100111: return makeCtrl(aluAdd, immS,    brNone, 10'b000_0100_010);
            7'b1010011: return makeCtrl(aluFp,  immI,    brNone, 10'b000_1000_101);
            default:    return makeCtrl(aluAdd, immI,    brNone, 10'b000_0000_001);
        endcase
    endfunction

    function automatic logic [`XLEN-1:0] expectImm(input logic [31:0] w, input immTypeT it);
        case (it)
            immI: return {{20{w[31]}}, w[31:20]};
            immS: return {{20{w[31]}}, w[31:25], w[11:7]};
            immB: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            immU: return {w[31:12], 12'b0};
            immJ: return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default: return '0;
        endcase
    endfunction

    function automatic idExT expectIdEx(input logic [31:0] w, input logic v);
        idExT r;
        r = '0;
        if (v) begin
            r.valid  = 1'b1;
            r.ctrl   = controlRow(w[6:0]);
            r.imm    = expectImm(w, r.ctrl.immType);
            r.rs1    = w[19:15];
            r.rs2    = w[24:20];
            r.rd     = w[11:7];
            r.funct3 = w[14:12];
            r.funct7 = w[31:25];
        end
        return r;
    endfunction

    task automatic checkEq(input logic [$bits(idExT)-1:0] got,
                           input logic [$bits(idExT)-1:0] exp, input string what);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    task automatic drive(input logic [31:0] word, input logic v, input logic s, input logic f);
        instr      = word;
        instrValid = v;
        stall      = s;
        flush      = f;
        @(negedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Model register with the reset, flush and stall rules of the stage
    always @(posedge clk) begin
        if (!rstN || flush) begin
            model = '0;
        end else if (!stall) begin
            model = expectIdEx(instr, instrValid);
        end
    end

    always @(negedge clk) begin
        checkEq(idEx, model, "idEx record");
    end

    initial begin
        #((numCycles + 100) * 20);
        $display("Timeout: the run did not finish in the expected number of cycles");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        idExT held;
        logic [31:0] word;
        logic [6:0] op;
        rstN       = 1'b0;
        instr      = '0;
        instrValid = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        rng        = 32'd62;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
        checkEq(idEx, '0, "idEx after reset");

        foreach (opList[i]) begin
            rng = xorshift(rng);
            drive({1'b0, rng[30:7], opList[i]}, 1'b1, 1'b0, 1'b0);
            rng = xorshift(rng);
            drive({1'b1, rng[30:7], opList[i]}, 1'b1, 1'b0, 1'b0);  // Negative immediate
        end
        drive({rng[31:7], 7'b1111111}, 1'b1, 1'b0, 1'b0);  // Unlisted opcode
        drive(`NOP_INSTR, 1'b1, 1'b0, 1'b0);
        drive(rng, 1'b0, 1'b0, 1'b0);
        checkEq(idEx, '0, "idEx for an invalid instruction");

        rng  = xorshift(rng);
        word = {rng[31:7], 7'b0110011};
        drive(word, 1'b1, 1'b0, 1'b0);
        held = expectIdEx(word, 1'b1);
        repeat (4) begin
            rng = xorshift(rng);
            drive({rng[31:7], 7'b0000011}, 1'b1, 1'b1, 1'b0);
        end
        checkEq(idEx, held, "idEx during stall");
        drive({rng[31:7], 7'b0100011}, 1'b1, 1'b0, 1'b0);
        drive({rng[31:7], 7'b0010011}, 1'b1, 1'b1, 1'b1);  // Flush beats stall
        checkEq(idEx, '0, "idEx after flush under stall");

        for (int i = 0; i < numRandom; i++) begin
            rng  = xorshift(rng);
            word = rng;
            rng  = xorshift(rng);
            op   = (rng[3:0] < 4'd13) ? opList[rng[3:0]] : rng[10:4];
            drive({word[31:7], op}, rng[20] | rng[21], rng[13:12] == 2'b00,
                  rng[19:16] == 4'h0);
        end
        @(posedge clk);  // Last compare at the previous falling edge is done

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: tests/DecodeStage_sva.sv
module DecodeStageSva (
    input logic             clk,
    input logic             rstN,
    input logic             stall,
    input logic             flush,
    input DecodePkg::idExT  idEx
);

    timeunit 1ns;
    timeprecision 1ps;

    // Bubble in the cycle after reset or flush
    clearAfterResetOrFlush: assert property (
        @(posedge clk) (!rstN || flush) |=> (idEx == '0)
    ) else $error("idEx not cleared after reset or flush");

    holdOnStall: assert property (
        @(posedge clk) disable iff (!rstN) (stall && !flush) |=> $stable(idEx)
    ) else $error("idEx changed during a stall");

    // No opcode both stores and writes a register
    noStoreAndWrite: assert property (
        @(posedge clk) disable iff (!rstN) !(idEx.ctrl.memWrite && idEx.ctrl.regWrite)
    ) else $error("memWrite and regWrite both set");

endmodule

// File: verilog/ControlUnit.sv
`include "decode_params.svh"

module ControlUnit (
    input  logic [`OPW-1:0] opcode,
    output DecodePkg::ctrlT ctrl
);

    import DecodePkg::*;

    localparam logic [`OPW-1:0] opR      = 7'b0110011;
    localparam logic [`OPW-1:0] opLoad   = 7'b0000011;
    localparam logic [`OPW-1:0] opImm    = 7'b0010011;
    localparam logic [`OPW-1:0] opJalr   = 7'b1100111;
    localparam logic [`OPW-1:0] opStore  = 7'b0100011;
    localparam logic [`OPW-1:0] opBranch = 7'b1100011;
    localparam logic [`OPW-1:0] opAuipc  = 7'b0010111;
    localparam logic [`OPW-1:0] opLui    = 7'b0110111;
    localparam logic [`OPW-1:0] opJal    = 7'b1101111;
    localparam logic [`OPW-1:0] opCsr    = 7'b1110011;
    localparam logic [`OPW-1:0] opFlw    = 7'b0000111;
    localparam logic [`OPW-1:0] opFsw    = 7'b0100111;
    localparam logic [`OPW-1:0] opFp     = 7'b1010011;

    // Field order follows ctrlT
    //   aluOp, aluSrc, pcToRegSrc, immType, rdSrc,
    //   memToReg, memWrite, memRead, regWrite, branch, regWriteF, aluSelF, memInF
    always_comb begin
        case (opcode)
            opR: begin
                ctrl = '{aluR, 1'b1, 1'b0, immNone, 1'b0,
                         1'b1, 1'b0, 1'b0, 1'b1, brNone, 1'b0, 1'b1, 1'b1};
            end
            opLoad: begin
                ctrl = '{aluAdd, 1'b0, 1'b0, immI, 1'b0,
                         1'b0, 1'b0, 1'b1, 1'b1, brNone, 1'b0, 1'b1, 1'b1};
            end
            opImm: begin
                ctrl = '{aluI, 1'b0, 1'b0, immI, 1'b0,
                         1'b1, 1'b0, 1'b0, 1'b1, brNone, 1'b0, 1'b1, 1'b1};
            end
            opJalr: begin
                ctrl = '{aluAdd, 1'b0, 1'b0, immI, 1'b1,
                         1'b1, 1'b0, 1'b0, 1'b1, brJalr, 1'b0, 1'b1, 1'b1};
            end
            opStore: begin
                ctrl = '{aluAdd, 1'b0, 1'b0, immS, 1'b0,
                         1'b0, 1'b1, 1'b0, 1'b0, brNone, 1'b0, 1'b1, 1'b1};
            end
            opBranch: begin  // Compare in ALU, target from pc + imm
                ctrl = '{aluBr, 1'b1, 1'b1, immB, 1'b1,
                         1'b0, 1'b0, 1'b0, 1'b0, brCond, 1'b0, 1'b1, 1'b1};
            end
            opAuipc: begin
                ctrl = '{aluAdd, 1'b0, 1'b1, immU, 1'b1,
                         1'b1, 1'b0, 1'b0, 1'b1, brNone, 1'b0, 1'b1, 1'b1};
            end
            opLui: begin
                ctrl = '{aluLui, 1'b0, 1'b0, immU, 1'b0,
                         1'b1, 1'b0, 1'b0, 1'b1, brNone, 1'b0, 1'b1, 1'b1};
            end
            opJal: begin
                ctrl = '{aluAdd, 1'b0, 1'b0, immJ, 1'b1,
                         1'b1, 1'b0, 1'b0, 1'b1, brJal, 1'b0, 1'b1, 1'b1};
            end
            opCsr: begin
                ctrl = '{aluCsr, 1'b0, 1'b0, immI, 1'b0,
                         1'b0, 1'b0, 1'b0, 1'b1, brNone, 1'b0, 1'b1, 1'b1};
            end
            opFlw: begin  // Load into the float file
                ctrl = '{aluAdd, 1'b0, 1'b0, immI, 1'b0,
                         1'b0, 1'b0, 1'b1, 1'b0, brNone, 1'b1, 1'b1, 1'b1};
            end
            opFsw: begin  // Store data from the float file
                ctrl = '{aluAdd, 1'b0, 1'b0, immS, 1'b0,
                         1'b0, 1'b1, 1'b0, 1'b0, brNone, 1'b0, 1'b1, 1'b0};
            end
            opFp: begin  // FADD.S and FSUB.S
                ctrl = '{aluFp, 1'b0, 1'b0, immI, 1'b0,
                         1'b1, 1'b0, 1'b0, 1'b0, brNone, 1'b1, 1'b0, 1'b1};
            end
            default: begin  // No writes, no branch
                ctrl = '{aluAdd, 1'b0, 1'b0, immI, 1'b0,
                         1'b0, 1'b0, 1'b0, 1'b0, brNone, 1'b0, 1'b0, 1'b1};
            end
        endcase
    end

endmodule

// File: verilog/DecodePkg.sv
`include "decode_params.svh"

package DecodePkg;

    typedef enum logic [2:0] {
        aluR   = 3'd0,
        aluI   = 3'd1,
        aluBr  = 3'd2,
        aluLui = 3'd3,
        aluCsr = 3'd4,
        aluFp  = 3'd5,
        aluAdd = 3'd6
    } aluOpT;

    typedef enum logic [2:0] {
        immI    = 3'd0,
        immS    = 3'd1,
        immB    = 3'd2,
        immU    = 3'd3,
        immJ    = 3'd4,
        immNone = 3'd5
    } immTypeT;

    typedef enum logic [1:0] {
        brNone = 2'd0,
        brJalr = 2'd1,
        brCond = 2'd2,
        brJal  = 2'd3
    } branchT;

    typedef struct packed {
        aluOpT   aluOp;
        logic    aluSrc;
        logic    pcToRegSrc;
        immTypeT immType;
        logic    rdSrc;      // Write back pc + 4
        logic    memToReg;
        logic    memWrite;
        logic    memRead;
        logic    regWrite;
        branchT  branch;
        logic    regWriteF;  // Float register file write
        logic    aluSelF;    // 0 picks the float ALU
        logic    memInF;     // 0 stores the float operand
    } ctrlT;

    typedef struct packed {
        logic [6:0]      funct7;
        logic [4:0]      rs2;
        logic [4:0]      rs1;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [`OPW-1:0] opcode;
    } rFmtT;

    typedef struct packed {
        logic [11:0]     imm;
        logic [4:0]      rs1;
        logic [2:0]      funct3;
        logic [4:0]      rd;
        logic [`OPW-1:0] opcode;
    } iFmtT;

    typedef struct packed {
        logic [6:0]      immHi;
        logic [4:0]      rs2;
        logic [4:0]      rs1;
        logic [2:0]      funct3;
        logic [4:0]      immLo;
        logic [`OPW-1:0] opcode;
    } sFmtT;

    typedef struct packed {
        logic            imm12;
        logic [5:0]      imm10To5;
        logic [4:0]      rs2;
        logic [4:0]      rs1;
        logic [2:0]      funct3;
        logic [3:0]      imm4To1;
        logic            imm11;
        logic [`OPW-1:0] opcode;
    } bFmtT;

    typedef struct packed {
        logic [19:0]     imm31To12;
        logic [4:0]      rd;
        logic [`OPW-1:0] opcode;
    } uFmtT;

    typedef struct packed {
        logic            imm20;
        logic [9:0]      imm10To1;
        logic            imm11;
        logic [7:0]      imm19To12;
        logic [4:0]      rd;
        logic [`OPW-1:0] opcode;
    } jFmtT;

    // Same word seen through each encoding
    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
        sFmtT sFmt;
        bFmtT bFmt;
        uFmtT uFmt;
        jFmtT jFmt;
    } instrT;

    typedef struct packed {
        logic             valid;
        ctrlT             ctrl;
        logic [`XLEN-1:0] imm;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [4:0]       rd;
        logic [2:0]       funct3;
        logic [6:0]       funct7;  // Bit 30 picks sub and sra
    } idExT;

endpackage

// File: verilog/DecodeStage.sv
`include "decode_params.svh"

module DecodeStage (
    input  logic             clk,
    input  logic             rstN,
    input  DecodePkg::instrT instr,
    input  logic             instrValid,
    input  logic             stall,
    input  logic             flush,
    output DecodePkg::idExT  idEx
);

    import DecodePkg::*;

    ctrlT             ctrl;
    logic [`XLEN-1:0] imm;

    ControlUnit uControl (
        .opcode (instr.rFmt.opcode),
        .ctrl   (ctrl)
    );

    ImmGen uImmGen (
        .instr   (instr),
        .immType (ctrl.immType),  // Format picked by the decoder
        .imm     (imm)
    );

    IdExReg uIdEx (
        .clk        (clk),
        .rstN       (rstN),
        .instr      (instr),
        .instrValid (instrValid),
        .ctrl       (ctrl),
        .imm        (imm),
        .stall      (stall),
        .flush      (flush),
        .idEx       (idEx)
    );

endmodule

// File: verilog/IdExReg.sv
`include "decode_params.svh"

module IdExReg (
    input  logic             clk,
    input  logic             rstN,
    input  DecodePkg::instrT instr,
    input  logic             instrValid,
    input  DecodePkg::ctrlT  ctrl,
    input  logic [`XLEN-1:0] imm,
    input  logic             stall,
    input  logic             flush,
    output DecodePkg::idExT  idEx
);

    import DecodePkg::*;

    idExT nextIdEx;

    // Register fields sit at the same bits in every format
    always_comb begin
        nextIdEx = '0;
        if (instrValid) begin
            nextIdEx.valid  = 1'b1;
            nextIdEx.ctrl   = ctrl;
            nextIdEx.imm    = imm;
            nextIdEx.rs1    = instr.rFmt.rs1;
            nextIdEx.rs2    = instr.rFmt.rs2;
            nextIdEx.rd     = instr.rFmt.rd;
            nextIdEx.funct3 = instr.rFmt.funct3;
            nextIdEx.funct7 = instr.rFmt.funct7;
        end
    end

    // All-zero record is the bubble, a harmless stand-in for `NOP_INSTR
    always_ff @(posedge clk) begin
        if (!rstN || flush) begin
            idEx <= '0;
        end else if (!stall) begin
            idEx <= nextIdEx;
        end
    end

endmodule

// File: verilog/ImmGen.sv
`include "decode_params.svh"

module ImmGen (
    input  DecodePkg::instrT   instr,
    input  DecodePkg::immTypeT immType,
    output logic [`XLEN-1:0]   imm
);

    import DecodePkg::*;

    logic signBit;

    assign signBit = instr.rFmt.funct7[6];  // instr[31] in every format

    always_comb begin
        case (immType)
            immI: begin
                imm = {{(`XLEN-12){signBit}}, instr.iFmt.imm};
            end
            immS: begin
                imm = {{(`XLEN-12){signBit}}, instr.sFmt.immHi, instr.sFmt.immLo};
            end
            immB: begin
                imm = {{(`XLEN-12){signBit}}, instr.bFmt.imm11,
                       instr.bFmt.imm10To5, instr.bFmt.imm4To1, 1'b0};
            end
            immU: begin
                imm = {instr.uFmt.imm31To12, 12'b0};
            end
            immJ: begin
                imm = {{(`XLEN-20){signBit}}, instr.jFmt.imm19To12, instr.jFmt.imm11,
                       instr.jFmt.imm10To1, 1'b0};
            end
            default: begin
                imm = '0;  // R-type has no immediate
            end
        endcase
    end

endmodule

// File: verilog/decode_params.svh
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data path and instruction word width
`define XLEN 32

// Major opcode field, instr[6:0]
`define OPW 7

// ADDI x0,x0,0, the canonical RV32I no-op
`define NOP_INSTR 32'h0000_0013

`endif
